// ==== include/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// serial frame format, shared by receiver and transmitter.

`define UART_CLOCK_DIVIDER 8  // clock cycles per serial bit.

`define UART_DATA_BITS 8  // 5 to 9 are supported.

`define UART_PARITY_BITS 1  // 1 adds an even parity bit after the data.

`define UART_STOP_BITS 1  // 1 or 2.

// start bit, data, parity and stop bits.
`define UART_FRAME_BITS (1 + `UART_DATA_BITS + `UART_PARITY_BITS + `UART_STOP_BITS)

`endif

// ==== hw/uart_pkg.sv ====
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

    // one character on the parallel side.
    typedef logic [`UART_DATA_BITS-1:0] dataWord_t;

    // whole frame, start bit in bit 0.
    typedef logic [`UART_FRAME_BITS-1:0] frame_t;

    typedef logic [$clog2(`UART_FRAME_BITS)-1:0] bitIdx_t;  // bit position in a frame.

    typedef logic [$clog2(`UART_CLOCK_DIVIDER+1)-1:0] divCount_t;  // cycles within a bit.

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_RECV,
        RX_DONE,
        RX_WAITIDLE
    } rxState_t;

    typedef enum logic {
        TX_IDLE,
        TX_SEND
    } txState_t;

endpackage

`default_nettype wire

// ==== hw/uartTx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uartTx (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire uart_pkg::dataWord_t txData,
    input  wire logic                txStart,
    output logic                     txBusy,
    output logic                     txLine
);

    localparam int DataLsb   = 1;
    localparam int DataMsb   = `UART_DATA_BITS;
    localparam int ParityIdx = `UART_DATA_BITS + 1;

    localparam uart_pkg::divCount_t LastCount =
        uart_pkg::divCount_t'(`UART_CLOCK_DIVIDER - 1);
    localparam uart_pkg::bitIdx_t LastBit = uart_pkg::bitIdx_t'(`UART_FRAME_BITS - 1);

    uart_pkg::txState_t  state;
    uart_pkg::divCount_t divCount;
    uart_pkg::bitIdx_t   bitIdx;
    uart_pkg::frame_t    shiftReg;
    uart_pkg::frame_t    loadFrame;

    logic bitDone;
    logic startOk;

    ////////////////////
    // frame build
    ////////////////////

    always_comb begin
        loadFrame                  = '1;  // stop bits.
        loadFrame[0]               = 1'b0;  // start bit.
        loadFrame[DataMsb:DataLsb] = txData;
        if (`UART_PARITY_BITS != 0) begin
            loadFrame[ParityIdx] = ^txData;
        end
    end

    assign startOk = txStart && (state == uart_pkg::TX_IDLE);  // dropped while busy.
    assign bitDone = (divCount == LastCount);

    assign txBusy = (state == uart_pkg::TX_SEND);
    assign txLine = (state == uart_pkg::TX_SEND) ? shiftReg[0] : 1'b1;

    ////////////////////
    // bit timing
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::TX_IDLE;
            divCount <= '0;
            bitIdx   <= '0;
        end else begin
            unique case (state)
                uart_pkg::TX_IDLE: begin
                    divCount <= '0;
                    bitIdx   <= '0;
                    if (startOk) begin
                        state <= uart_pkg::TX_SEND;
                    end
                end
                uart_pkg::TX_SEND: begin
                    if (bitDone) begin
                        divCount <= '0;
                        bitIdx   <= bitIdx + 1'b1;
                        if (bitIdx == LastBit) begin
                            state <= uart_pkg::TX_IDLE;  // last stop bit held in full.
                        end
                    end else begin
                        divCount <= divCount + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // lsb goes out first, idle level fills from the top.
    always_ff @(posedge clk) begin
        if (startOk) begin
            shiftReg <= loadFrame;
        end else if (state == uart_pkg::TX_SEND && bitDone) begin
            shiftReg <= {1'b1, shiftReg[`UART_FRAME_BITS-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== hw/uartRx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uartRx (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          rxLine,
    output uart_pkg::dataWord_t rxData,
    output logic               rxValid,
    output logic               rxBreak,
    output logic               rxError
);

    localparam int DataLsb   = 1;
    localparam int DataMsb   = `UART_DATA_BITS;
    localparam int ParityIdx = `UART_DATA_BITS + 1;
    localparam int StopLsb   = `UART_DATA_BITS + `UART_PARITY_BITS + 1;
    localparam int StopMsb   = `UART_FRAME_BITS - 1;

    localparam uart_pkg::divCount_t HalfCount =
        uart_pkg::divCount_t'(`UART_CLOCK_DIVIDER / 2);
    localparam uart_pkg::divCount_t LastCount =
        uart_pkg::divCount_t'(`UART_CLOCK_DIVIDER - 1);
    localparam uart_pkg::bitIdx_t LastBit = uart_pkg::bitIdx_t'(`UART_FRAME_BITS - 1);

    logic lineMeta;  // first synchronizer stage.
    logic lineSync;

    uart_pkg::rxState_t  state;
    uart_pkg::rxState_t  nextState;
    uart_pkg::divCount_t divCount;
    uart_pkg::bitIdx_t   bitIdx;
    uart_pkg::frame_t    frameReg;

    logic bitDone;
    logic lastSample;
    logic stopOk;
    logic parityOk;
    logic frameZero;

    ////////////////////
    // input synchronizer
    ////////////////////

    always_ff @(posedge clk) begin
        lineMeta <= rxLine;
        lineSync <= lineMeta;
    end

    assign bitDone    = (divCount == LastCount);  // mid-bit sample point.
    assign lastSample = (state == uart_pkg::RX_RECV) && bitDone && (bitIdx == LastBit);

    ////////////////////
    // frame check
    ////////////////////

    assign stopOk    = &frameReg[StopMsb:StopLsb];
    assign frameZero = (frameReg == '0);

    always_comb begin
        if (`UART_PARITY_BITS == 0) begin
            parityOk = 1'b1;
        end else begin
            parityOk = ((^frameReg[DataMsb:DataLsb]) == frameReg[ParityIdx]);  // even.
        end
    end

    always_comb begin
        nextState = state;
        rxValid   = 1'b0;
        rxBreak   = 1'b0;
        rxError   = 1'b0;
        unique case (state)
            uart_pkg::RX_IDLE: begin
                if (!lineSync) begin
                    nextState = uart_pkg::RX_RECV;  // start edge.
                end
            end
            uart_pkg::RX_RECV: begin
                if (lastSample) begin
                    nextState = uart_pkg::RX_DONE;
                end
            end
            uart_pkg::RX_DONE: begin
                if (stopOk && parityOk) begin
                    rxValid = 1'b1;
                end else if (frameZero) begin
                    rxBreak = 1'b1;
                end else begin
                    rxError = 1'b1;
                end
                // a low stop bit means the line may still be held low.
                if (frameReg[StopMsb]) begin
                    nextState = uart_pkg::RX_IDLE;
                end else begin
                    nextState = uart_pkg::RX_WAITIDLE;
                end
            end
            uart_pkg::RX_WAITIDLE: begin
                if (lineSync) begin
                    nextState = uart_pkg::RX_IDLE;
                end
            end
            default: begin
                nextState = uart_pkg::RX_IDLE;
            end
        endcase
    end

    ////////////////////
    // counters and state
    ////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= uart_pkg::RX_IDLE;
            divCount <= HalfCount;
            bitIdx   <= '0;
        end else begin
            state <= nextState;
            if (state != uart_pkg::RX_RECV) begin
                divCount <= HalfCount;  // preset so samples land mid-bit.
                bitIdx   <= '0;
            end else if (bitDone) begin
                divCount <= '0;
                bitIdx   <= bitIdx + 1'b1;
            end else begin
                divCount <= divCount + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == uart_pkg::RX_RECV && bitDone) begin
            frameReg[bitIdx] <= lineSync;
        end
        if (lastSample) begin
            rxData <= frameReg[DataMsb:DataLsb];  // data bits are complete by now.
        end
    end

endmodule

`default_nettype wire

// ==== hw/uartTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTop (
    input  wire logic                clk,
    input  wire logic                rst,

    // transmit side.
    input  wire uart_pkg::dataWord_t txData,
    input  wire logic                txStart,
    output logic                     txBusy,
    output logic                     txLine,

    // receive side.
    input  wire logic                rxLine,
    output uart_pkg::dataWord_t      rxData,
    output logic                     rxValid,
    output logic                     rxBreak,
    output logic                     rxError
);

    ////////////////////
    // transmitter
    ////////////////////

    uartTx i_uartTx (
        .clk     (clk),
        .rst     (rst),
        .txData  (txData),
        .txStart (txStart),
        .txBusy  (txBusy),
        .txLine  (txLine)
    );

    ////////////////////
    // receiver
    ////////////////////

    // independent line, only a testbench ties it to txLine.
    uartRx i_uartRx (
        .clk     (clk),
        .rst     (rst),
        .rxLine  (rxLine),
        .rxData  (rxData),
        .rxValid (rxValid),
        .rxBreak (rxBreak),
        .rxError (rxError)
    );

endmodule

`default_nettype wire

// ==== testbench/uart_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uartAsserts (
    input wire logic clk,
    input wire logic rst,
    input wire logic txBusy,
    input wire logic txLine,
    input wire logic rxValid,
    input wire logic rxBreak,
    input wire logic rxError
);

    localparam int BusyCycles = `UART_FRAME_BITS * `UART_CLOCK_DIVIDER;

    int busyCount;  // cycles busy in the current frame.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busyCount <= 0;
        end else begin
            busyCount <= txBusy ? busyCount + 1 : 0;
        end
    end

    idleLine: assert property (@(posedge clk) disable iff (rst) !txBusy |-> txLine)
        else $error("txLine is low while the transmitter is idle");
    oneResult: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rxValid, rxBreak, rxError}))
        else $error("more than one receive result in the same cycle");
    shortResult: assert property (@(posedge clk) disable iff (rst)
        (rxValid || rxBreak || rxError) |=> !(rxValid || rxBreak || rxError))
        else $error("receive result held for more than one cycle");
    busyLength: assert property (@(posedge clk) disable iff (rst)
        $fell(txBusy) |-> busyCount == BusyCycles)
        else $error("txBusy did not last exactly one frame");
    busyLimit: assert property (@(posedge clk) disable iff (rst)
        txBusy |-> busyCount < BusyCycles)
        else $error("txBusy stayed high longer than one frame");

endmodule

bind uartTop uartAsserts i_uartAsserts (
    .clk     (clk),
    .rst     (rst),
    .txBusy  (txBusy),
    .txLine  (txLine),
    .rxValid (rxValid),
    .rxBreak (rxBreak),
    .rxError (rxError)
);

`default_nettype wire

// ==== testbench/uartTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uartTb;

    localparam int DataBits    = `UART_DATA_BITS;
    localparam int BitCycles   = `UART_CLOCK_DIVIDER;
    localparam int FrameCycles = `UART_FRAME_BITS * `UART_CLOCK_DIVIDER;
    localparam int CycleLimit  = 4000;  // about 25 frames plus margin.

    // outcome kinds, stored above the data bits of each entry.
    localparam logic [1:0] KindValid = 2'd0;
    localparam logic [1:0] KindBreak = 2'd1;
    localparam logic [1:0] KindError = 2'd2;
    localparam logic [1:0] KindNone  = 2'd3;

    logic                clk;
    logic                rst;
    uart_pkg::dataWord_t txData;
    logic                txStart;
    logic                txBusy;
    logic                txLine;
    logic                rxLine;
    uart_pkg::dataWord_t rxData;
    logic                rxValid;
    logic                rxBreak;
    logic                rxError;

    logic useLoopback;
    logic injectLine;

    logic [DataBits+1:0] expected[$];  // oldest first.
    logic [DataBits+1:0] got;
    logic [DataBits+1:0] want;
    logic                checkPending = 1'b0;

    string testName;
    int    errors;
    int    seed;
    int    cycleCount;

    assign rxLine = useLoopback ? txLine : injectLine;

    uartTop i_uartTop (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // stimulus tasks
    ////////////////////

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic sendByte(input uart_pkg::dataWord_t value);
        while (txBusy) begin
            nextCycle();
        end
        txData  = value;
        txStart = 1'b1;
        expected.push_back({KindValid, value});
        nextCycle();
        txStart = 1'b0;
    endtask

    task automatic injectFrame(input uart_pkg::dataWord_t value, input logic flipParity,
                               input logic stopLevel, input logic [1:0] kind);
        logic [`UART_FRAME_BITS-1:0] bits;
        bits              = '1;
        bits[0]           = 1'b0;
        bits[DataBits:1]  = value;
        if (`UART_PARITY_BITS != 0) begin
            bits[DataBits+1] = (^value) ^ flipParity;
        end
        bits[`UART_FRAME_BITS-1 -: `UART_STOP_BITS] = {`UART_STOP_BITS{stopLevel}};
        expected.push_back({kind, value});
        for (int i = 0; i < `UART_FRAME_BITS; i++) begin
            injectLine = bits[i];
            repeat (BitCycles) nextCycle();
        end
        injectLine = 1'b1;
        repeat (2 * BitCycles) nextCycle();  // idle gap.
    endtask

    task automatic drainQueue();
        int waited;
        waited = 0;
        while ((expected.size() != 0 || txBusy) && waited < 2 * FrameCycles) begin
            nextCycle();
            waited++;
        end
        repeat (BitCycles) nextCycle();
        missing: assert (expected.size() == 0) else begin
            $display("%s: %0d expected characters were never received",
                     testName, expected.size());
            errors++;
            expected.delete();
        end
    endtask

    ////////////////////
    // scoreboard
    ////////////////////

    always @(posedge clk) begin
        checkPending <= !rst && (rxValid || rxBreak || rxError);
        if (!rst && (rxValid || rxBreak || rxError)) begin
            got  <= {rxValid ? KindValid : (rxBreak ? KindBreak : KindError), rxData};
            want <= (expected.size() != 0) ? expected.pop_front() : {KindNone, rxData};
        end
    end

    receiveMatch: assert property (@(posedge clk) disable iff (rst)
        checkPending |-> (got == want))
        else begin
            $display("[ERROR] %s: expected kind %0d data 0x%0h, actual kind %0d data 0x%0h",
                     testName, want[DataBits+1:DataBits], want[DataBits-1:0],
                     got[DataBits+1:DataBits], got[DataBits-1:0]);
            errors++;
        end

    resetState: assert property (@(posedge clk)
        (rst || $past(rst)) |-> txLine && !txBusy && !rxValid && !rxBreak && !rxError)
        else begin
            $display("outputs left their reset values during or right after reset");
            errors++;
        end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        rst         = 1'b1;
        txData      = '0;
        txStart     = 1'b0;
        useLoopback = 1'b1;
        injectLine  = 1'b1;
        errors      = 0;
        seed        = 35;
        testName    = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (2) nextCycle();

        testName = "loopback fixed";
        sendByte(8'h00);
        sendByte(8'hFF);
        sendByte(8'h55);
        sendByte(8'hA5);
        drainQueue();

        testName = "loopback random";
        repeat (16) begin
            sendByte(uart_pkg::dataWord_t'($random(seed)));
        end
        drainQueue();

        testName = "start while busy";
        sendByte(8'h3C);
        repeat (FrameCycles / 2) nextCycle();
        txData  = 8'hC3;  // lands mid-frame.
        txStart = 1'b1;
        nextCycle();
        txStart = 1'b0;
        drainQueue();

        useLoopback = 1'b0;
        testName = "bad parity";
        injectFrame(8'h5A, 1'b1, 1'b1, KindError);
        injectFrame(8'h81, 1'b0, 1'b1, KindValid);
        testName = "bad stop";
        injectFrame(8'h7E, 1'b0, 1'b0, KindError);
        injectFrame(8'h42, 1'b0, 1'b1, KindValid);
        drainQueue();

        testName = "break";
        expected.push_back({KindBreak, 8'h00});
        injectLine = 1'b0;
        repeat (3 * FrameCycles) nextCycle();
        injectLine = 1'b1;
        repeat (2 * BitCycles) nextCycle();
        injectFrame(8'h96, 1'b0, 1'b1, KindValid);
        drainQueue();

        $display("Tests complete with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
hw/uart_pkg.sv
hw/uartTx.sv
hw/uartRx.sv
hw/uartTop.sv
testbench/uart_asserts.sv
testbench/uartTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= uartTb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
BUILD_ARGS ?= --binary --timing --assert -j 0
LINT_ARGS  ?= --lint-only --timing --assert
SIM_ARGS   ?=

SOURCES := $(FILELIST) $(wildcard include/*.svh hw/*.sv testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES)
	$(VERILATOR) $(BUILD_ARGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Errors found" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	fi; \
	echo "PASS"

lint:
	$(VERILATOR) $(LINT_ARGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
